// File: hdl/soc_dev_pkg.sv
package soc_dev_pkg;

    // ------------------------------------------------------------------
    // bus widths
    localparam int DATA_W      = 32;  // device and axi data
    localparam int DEV_ADDR_W  = 32;
    localparam int AXIL_ADDR_W = 7;   // spi core register window
    localparam int RST_CYCLES  = 8;   // default reset stretch

    typedef logic [DEV_ADDR_W-1:0]  dev_addr_t;
    typedef logic [DATA_W-1:0]      dev_data_t;
    typedef logic [DATA_W/8-1:0]    dev_strb_t;
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [1:0]             axil_resp_t;
    typedef logic [7:0]             spi_byte_t;

    // device map, top address byte
    localparam logic [7:0] SPI_TAG = 8'hC2;

    // spi controller register offsets
    localparam axil_addr_t REG_STATUS = 7'h00;  // bit 0 busy
    localparam axil_addr_t REG_DIV    = 7'h04;  // sck half period - 1
    localparam axil_addr_t REG_TXDATA = 7'h08;  // write starts a byte
    localparam axil_addr_t REG_RXDATA = 7'h0C;  // last received byte

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {BR_IDLE, BR_WRITE_WAIT, BR_READ_WAIT, BR_DONE} bridge_state_t;

endpackage

// File: hdl/axil_if.sv
`timescale 1ns/1ps

interface axil_if #(parameter int DATA_W = soc_dev_pkg::DATA_W);
    import soc_dev_pkg::*;

    // write address / data / response
    logic                awvalid;
    logic                awready;
    axil_addr_t          awaddr;
    logic                wvalid;
    logic                wready;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                bvalid;
    logic                bready;
    axil_resp_t          bresp;
    // read address / data
    logic                arvalid;
    logic                arready;
    axil_addr_t          araddr;
    logic                rvalid;
    logic                rready;
    logic [DATA_W-1:0]   rdata;
    axil_resp_t          rresp;

    modport master (output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
                    input awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp);
    modport slave (input awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
                   output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp);

endinterface

// File: hdl/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch #(
    parameter int RST_CYCLES = soc_dev_pkg::RST_CYCLES
) (
    input  logic clk,
    input  logic rst,
    output logic core_rst_o
);

    localparam int CNT_W = $clog2(RST_CYCLES + 1);

    logic [CNT_W-1:0] rst_cnt;  // cycles of reset left

    always_ff @(posedge clk)
    begin
        if (rst)
            rst_cnt <= CNT_W'(RST_CYCLES);     // reload while system reset is up
        else if (rst_cnt != '0)
            rst_cnt <= rst_cnt - 1'b1;         // count down, stick at zero
    end

    assign core_rst_o = (rst_cnt != '0);

endmodule

// File: hdl/dev_decoder.sv
`timescale 1ns/1ps

module dev_decoder (
    input  logic                  clk,
    input  logic                  core_rst_i,
    input  logic                  dev_strobe_i,
    input  soc_dev_pkg::dev_addr_t dev_addr_i,
    output soc_dev_pkg::dev_data_t dev_dout_o,
    output logic                  dev_ready_o,
    output logic                  spi_req_o,
    input  logic                  spi_ready_i,
    input  soc_dev_pkg::dev_data_t spi_rdata_i
);
    import soc_dev_pkg::*;

    logic spi_sel;      // address falls in the spi window
    logic nomap_ready;  // dummy completion for unmapped space
    logic pending;      // an access is in flight

    // device select from the top address byte, held by the master until ready
    assign spi_sel   = (dev_addr_i[DEV_ADDR_W-1 -: 8] == SPI_TAG);
    assign spi_req_o = dev_strobe_i & spi_sel;

    always_ff @(posedge clk)
    begin
        if (core_rst_i)
            nomap_ready <= 1'b0;
        else
            nomap_ready <= dev_strobe_i & ~spi_sel;  // answer one cycle later
    end

    // response mux, unmapped reads come back as zero
    assign dev_ready_o = spi_ready_i | nomap_ready;
    assign dev_dout_o  = spi_sel ? spi_rdata_i : '0;

    always_ff @(posedge clk)
    begin
        if (core_rst_i)
            pending <= 1'b0;
        else if (dev_strobe_i)
            pending <= 1'b1;
        else if (dev_ready_o)
            pending <= 1'b0;
    end

    // a completion, whether from the bridge or the local responder, needs a request
    a_ready_has_access: assert property (@(posedge clk) disable iff (core_rst_i)
        dev_ready_o |-> pending);

endmodule

// File: hdl/axil_dev_bridge.sv
`timescale 1ns/1ps

module axil_dev_bridge #(
    parameter int DATA_W = soc_dev_pkg::DATA_W
) (
    input  logic                   clk,
    input  logic                   core_rst_i,
    input  logic                   spi_req_i,
    input  soc_dev_pkg::dev_addr_t dev_addr_i,
    input  logic                   dev_we_i,
    input  logic [DATA_W/8-1:0]    dev_be_i,
    input  logic [DATA_W-1:0]      dev_din_i,
    output logic                   spi_ready_o,
    output logic [DATA_W-1:0]      spi_rdata_o,
    axil_if.master                 m
);
    import soc_dev_pkg::*;

    bridge_state_t     state;
    logic [DATA_W-1:0] rdata_q;  // read data held for the device bus

    // ------------------------------------------------------------------
    // control fsm, one access at a time
    always_ff @(posedge clk)
    begin
        if (core_rst_i)
        begin
            state     <= BR_IDLE;
            m.awvalid <= 1'b0;
            m.wvalid  <= 1'b0;
            m.bready  <= 1'b0;
            m.arvalid <= 1'b0;
            m.rready  <= 1'b0;
        end
        else
        begin
            case (state)
                BR_IDLE:
                begin
                    if (spi_req_i && dev_we_i)
                    begin
                        m.awvalid <= 1'b1;  // aw and w go out together
                        m.wvalid  <= 1'b1;
                        m.bready  <= 1'b1;
                        state     <= BR_WRITE_WAIT;
                    end
                    else if (spi_req_i)
                    begin
                        m.arvalid <= 1'b1;
                        m.rready  <= 1'b1;
                        state     <= BR_READ_WAIT;
                    end
                end
                BR_WRITE_WAIT:
                begin
                    if (m.awvalid && m.awready)
                        m.awvalid <= 1'b0;
                    if (m.wvalid && m.wready)
                        m.wvalid <= 1'b0;
                    if (m.bvalid && m.bready)
                    begin
                        m.bready <= 1'b0;  // response taken
                        state    <= BR_DONE;
                    end
                end
                BR_READ_WAIT:
                begin
                    if (m.arvalid && m.arready)
                        m.arvalid <= 1'b0;
                    if (m.rvalid && m.rready)
                    begin
                        m.rready <= 1'b0;
                        state    <= BR_DONE;
                    end
                end
                default:
                    state <= BR_IDLE;  // done lasts one cycle
            endcase
        end
    end

    // ------------------------------------------------------------------
    // request payload, captured with the strobe
    always_ff @(posedge clk)
    begin
        if (state == BR_IDLE && spi_req_i)
        begin
            m.awaddr <= dev_addr_i[AXIL_ADDR_W-1:0];
            m.araddr <= dev_addr_i[AXIL_ADDR_W-1:0];
            m.wdata  <= dev_din_i;
            m.wstrb  <= dev_be_i;
        end
        if (m.rvalid && m.rready)
            rdata_q <= m.rdata;
    end

    assign spi_ready_o = (state == BR_DONE);  // one cycle after b or r handshake
    assign spi_rdata_o = rdata_q;

    // valid and payload hold under back-pressure from the slave
    a_aw_stable: assert property (@(posedge clk) disable iff (core_rst_i)
        m.awvalid && !m.awready |=> m.awvalid && $stable(m.awaddr));
    a_w_stable: assert property (@(posedge clk) disable iff (core_rst_i)
        m.wvalid && !m.wready |=> m.wvalid && $stable(m.wdata) && $stable(m.wstrb));
    a_ar_stable: assert property (@(posedge clk) disable iff (core_rst_i)
        m.arvalid && !m.arready |=> m.arvalid && $stable(m.araddr));
    // the decoder must not issue while an access is still open
    a_req_when_idle: assert property (@(posedge clk) disable iff (core_rst_i)
        spi_req_i |-> state == BR_IDLE);

endmodule

// File: hdl/spi_regs.sv
`timescale 1ns/1ps

module spi_regs #(
    parameter int DATA_W = soc_dev_pkg::DATA_W
) (
    input  logic                   clk,
    input  logic                   core_rst_i,
    axil_if.slave                  s,
    output logic                   start_o,
    output soc_dev_pkg::spi_byte_t tx_byte_o,
    output soc_dev_pkg::spi_byte_t div_o,
    input  logic                   busy_i,
    input  soc_dev_pkg::spi_byte_t rx_byte_i,
    input  logic                   done_i
);
    import soc_dev_pkg::*;

    logic      wr_accept;  // aw and w taken in the same cycle
    logic      rd_accept;
    spi_byte_t div_q;
    spi_byte_t tx_q;
    spi_byte_t rx_q;
    logic      start_q;

    assign wr_accept = s.awvalid & s.wvalid & ~s.bvalid;
    assign s.awready = wr_accept;
    assign s.wready  = wr_accept;
    assign s.arready = ~s.rvalid;  // one read in flight
    assign rd_accept = s.arvalid & s.arready;

    // ------------------------------------------------------------------
    // write path
    always_ff @(posedge clk)
    begin
        if (core_rst_i)
        begin
            s.bvalid <= 1'b0;
            div_q    <= '0;
            start_q  <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;  // single cycle pulse
            if (wr_accept)
                s.bvalid <= 1'b1;
            else if (s.bready)
                s.bvalid <= 1'b0;
            if (wr_accept && s.awaddr == REG_DIV && s.wstrb[0])
                div_q <= s.wdata[7:0];
            // txdata while busy is dropped
            if (wr_accept && s.awaddr == REG_TXDATA && s.wstrb[0] && !busy_i && !start_q)
                start_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_accept && s.awaddr == REG_TXDATA && s.wstrb[0] && !busy_i && !start_q)
            tx_q <= s.wdata[7:0];
        if (wr_accept)
            s.bresp <= (s.awaddr > REG_RXDATA || s.awaddr[1:0] != 2'b00) ? RESP_SLVERR : RESP_OKAY;
        if (done_i)
            rx_q <= rx_byte_i;  // keep the last received byte
    end

    // ------------------------------------------------------------------
    // read path, data one cycle after ar
    always_ff @(posedge clk)
    begin
        if (core_rst_i)
            s.rvalid <= 1'b0;
        else if (rd_accept)
            s.rvalid <= 1'b1;
        else if (s.rready)
            s.rvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            s.rresp <= RESP_OKAY;
            case (s.araddr)
                REG_STATUS: s.rdata <= {{(DATA_W-1){1'b0}}, busy_i};
                REG_DIV:    s.rdata <= {{(DATA_W-8){1'b0}}, div_q};
                REG_TXDATA: s.rdata <= {{(DATA_W-8){1'b0}}, tx_q};
                REG_RXDATA: s.rdata <= {{(DATA_W-8){1'b0}}, rx_q};
                default:
                begin
                    s.rdata <= '0;  // hole in the map
                    s.rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    assign start_o   = start_q;
    assign tx_byte_o = tx_q;
    assign div_o     = div_q;

endmodule

// File: hdl/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter (
    input  logic                   clk,
    input  logic                   core_rst_i,
    input  logic                   start_i,
    input  soc_dev_pkg::spi_byte_t tx_byte_i,
    input  soc_dev_pkg::spi_byte_t div_i,
    output logic                   busy_o,
    output soc_dev_pkg::spi_byte_t rx_byte_o,
    output logic                   done_o,
    output logic                   spi_sck_o,
    output logic                   spi_mosi_o,
    input  logic                   spi_miso_i,
    output logic                   spi_ss_o
);
    import soc_dev_pkg::*;

    logic      busy_q;
    logic      sck_q;
    logic      done_q;
    spi_byte_t div_l;     // divider frozen for the byte
    spi_byte_t div_cnt;
    logic [3:0] edge_cnt; // 16 sck edges per byte
    spi_byte_t tx_sr;
    spi_byte_t rx_sr;

    always_ff @(posedge clk)
    begin
        if (core_rst_i)
        begin
            busy_q   <= 1'b0;
            sck_q    <= 1'b0;   // mode 0 idles low
            done_q   <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!busy_q && start_i)
            begin
                busy_q   <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
            end
            else if (busy_q && div_cnt == div_l)
            begin
                div_cnt  <= '0;
                sck_q    <= ~sck_q;
                edge_cnt <= edge_cnt + 1'b1;
                if (edge_cnt == 4'd15)
                begin
                    busy_q <= 1'b0;  // last falling edge ends the byte
                    done_q <= 1'b1;
                end
            end
            else if (busy_q)
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // shift registers, msb first
    always_ff @(posedge clk)
    begin
        if (!busy_q && start_i)
        begin
            tx_sr <= tx_byte_i;
            div_l <= div_i;
        end
        else if (busy_q && div_cnt == div_l && !sck_q)
            rx_sr <= {rx_sr[6:0], spi_miso_i};  // sample on rising sck
        else if (busy_q && div_cnt == div_l)
            tx_sr <= {tx_sr[6:0], 1'b0};        // next bit on falling sck
    end

    assign busy_o     = busy_q;
    assign done_o     = done_q;
    assign rx_byte_o  = rx_sr;
    assign spi_sck_o  = sck_q;
    assign spi_mosi_o = busy_q & tx_sr[7];
    assign spi_ss_o   = ~busy_q;  // low for the whole byte

    // register block must hold off txdata until the byte is out
    a_no_start_busy: assert property (@(posedge clk) disable iff (core_rst_i)
        start_i |-> !busy_o);

endmodule

// File: hdl/dev_subsys_top.sv
`timescale 1ns/1ps

module dev_subsys_top #(
    parameter int RST_CYCLES = soc_dev_pkg::RST_CYCLES,
    parameter int DATA_W     = soc_dev_pkg::DATA_W
) (
    input  logic                   clk,
    input  logic                   rst,
    // device bus
    input  logic                   dev_strobe_i,
    input  soc_dev_pkg::dev_addr_t dev_addr_i,
    input  logic                   dev_we_i,
    input  soc_dev_pkg::dev_strb_t dev_be_i,
    input  soc_dev_pkg::dev_data_t dev_din_i,
    output soc_dev_pkg::dev_data_t dev_dout_o,
    output logic                   dev_ready_o,
    // sd card
    output logic                   spi_sck_o,
    output logic                   spi_mosi_o,
    input  logic                   spi_miso_i,
    output logic                   spi_ss_o
);
    import soc_dev_pkg::*;

    logic      core_rst;
    logic      spi_req;
    logic      spi_ready;
    dev_data_t spi_rdata;
    logic      start;
    spi_byte_t tx_byte;
    spi_byte_t div;
    logic      busy;
    spi_byte_t rx_byte;
    logic      done;

    axil_if #(.DATA_W(DATA_W)) u_axil ();

    // ------------------------------------------------------------------
    reset_stretch #(.RST_CYCLES(RST_CYCLES)) u_reset_stretch (
        .clk(clk), .rst(rst), .core_rst_o(core_rst)
    );

    dev_decoder u_dev_decoder (
        .clk(clk), .core_rst_i(core_rst), .dev_strobe_i(dev_strobe_i), .dev_addr_i(dev_addr_i),
        .dev_dout_o(dev_dout_o), .dev_ready_o(dev_ready_o), .spi_req_o(spi_req),
        .spi_ready_i(spi_ready), .spi_rdata_i(spi_rdata)
    );

    axil_dev_bridge #(.DATA_W(DATA_W)) u_axil_dev_bridge (
        .clk(clk), .core_rst_i(core_rst), .spi_req_i(spi_req), .dev_addr_i(dev_addr_i),
        .dev_we_i(dev_we_i), .dev_be_i(dev_be_i), .dev_din_i(dev_din_i),
        .spi_ready_o(spi_ready), .spi_rdata_o(spi_rdata), .m(u_axil.master)
    );

    spi_regs #(.DATA_W(DATA_W)) u_spi_regs (
        .clk(clk), .core_rst_i(core_rst), .s(u_axil.slave), .start_o(start),
        .tx_byte_o(tx_byte), .div_o(div), .busy_i(busy), .rx_byte_i(rx_byte), .done_i(done)
    );

    spi_shifter u_spi_shifter (
        .clk(clk), .core_rst_i(core_rst), .start_i(start), .tx_byte_i(tx_byte), .div_i(div),
        .busy_o(busy), .rx_byte_o(rx_byte), .done_o(done), .spi_sck_o(spi_sck_o),
        .spi_mosi_o(spi_mosi_o), .spi_miso_i(spi_miso_i), .spi_ss_o(spi_ss_o)
    );

endmodule

// File: verification/tb_dev_subsys.sv
`timescale 1ns/1ps

module tb_dev_subsys;
    import soc_dev_pkg::*;

    localparam spi_byte_t DIV_A = 8'd1;  // fast sck
    localparam spi_byte_t DIV_B = 8'd6;  // slow sck, largest divider in the run
    localparam int ACCESS_LIMIT   = 16;  // cycles from strobe to ready
    localparam int POLL_LIMIT     = 64;  // status reads per transfer
    localparam int TIMEOUT_CYCLES = 10 * 16 * (DIV_B + 1);  // ten slow bytes

    logic      clk;
    logic      rst;
    logic      dev_strobe;
    dev_addr_t dev_addr;
    logic      dev_we;
    dev_strb_t dev_be;
    dev_data_t dev_din;
    dev_data_t dev_dout;
    logic      dev_ready;
    logic      spi_sck;
    logic      spi_mosi;
    logic      spi_ss;

    int        mismatch_errs = 0;
    int        other_errs    = 0;
    int        cycles        = 0;
    int        sck_rises     = 0;
    int        ss_low        = 0;   // cycles of the current ss window
    int        xfers         = 0;   // completed bytes seen on the pins
    spi_byte_t exp_div       = '0;  // divider of the byte in flight
    logic      sck_prev      = 1'b0;
    logic      ss_prev       = 1'b1;
    logic [7:0] lfsr_state   = 8'd57;

    dev_subsys_top #(.RST_CYCLES(RST_CYCLES), .DATA_W(DATA_W)) u_dev_subsys_top (
        .clk(clk), .rst(rst), .dev_strobe_i(dev_strobe), .dev_addr_i(dev_addr),
        .dev_we_i(dev_we), .dev_be_i(dev_be), .dev_din_i(dev_din), .dev_dout_o(dev_dout),
        .dev_ready_o(dev_ready), .spi_sck_o(spi_sck), .spi_mosi_o(spi_mosi),
        .spi_miso_i(spi_mosi), .spi_ss_o(spi_ss)  // loopback
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------
    // helpers
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        // x^8 + x^6 + x^5 + x^4 + 1, right shifting
        lfsr_step = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic rand_byte(output spi_byte_t b);
        for (int i = 0; i < 8; i++)
        begin
            b = {b[6:0], lfsr_state[0]};  // one lfsr step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic dev_addr_t spi_addr(input axil_addr_t off);
        spi_addr = {SPI_TAG, 17'h0, off};
    endfunction

    task automatic compare_word(input string name, input dev_data_t got, input dev_data_t exp);
        assert (got === exp)
        else
        begin
            mismatch_errs++;
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // one device bus access, strobe for a cycle, inputs held until ready
    task automatic dev_access(input dev_addr_t addr, input logic we, input dev_strb_t be,
                              input dev_data_t din, output dev_data_t dout, output int lat);
        int n;
        @(posedge clk);
        dev_strobe <= 1'b1;
        dev_addr   <= addr;
        dev_we     <= we;
        dev_be     <= be;
        dev_din    <= din;
        @(posedge clk);
        dev_strobe <= 1'b0;
        n    = 0;
        lat  = -1;
        dout = '0;
        while (lat < 0 && n < ACCESS_LIMIT)
        begin
            @(posedge clk);
            n++;
            if (dev_ready)
            begin
                lat  = n;  // cycles after the strobe cycle
                dout = dev_dout;
            end
        end
        if (lat < 0)
        begin
            other_errs++;
            $display("no dev_ready_o within %0d cycles for address 0x%h", ACCESS_LIMIT, addr);
        end
    endtask

    // poll status until the shift engine drops busy
    task automatic wait_idle();
        dev_data_t st;
        int        lat;
        int        polls;
        polls = 0;
        st    = 32'h1;
        while (st[0] && polls < POLL_LIMIT)
        begin
            dev_access(spi_addr(REG_STATUS), 1'b0, 4'hF, '0, st, lat);
            polls++;
        end
        if (st[0])
        begin
            other_errs++;
            $display("spi transfer still busy after %0d status reads", polls);
        end
    endtask

    // ------------------------------------------------------------------
    // pins quiet while the stretched reset is up
    a_idle_during_stretch: assert property (@(posedge clk)
        (cycles > 2 && u_dev_subsys_top.core_rst) |-> (spi_ss && !spi_sck && !dev_ready))
    else
    begin
        mismatch_errs++;
        $display("mismatch reset state spi_ss_o 0x%h spi_sck_o 0x%h dev_ready_o 0x%h",
                 $sampled(spi_ss), $sampled(spi_sck), $sampled(dev_ready));
    end

    // sck rising edges and window length inside each slave select window
    always @(posedge clk)
    begin
        if (!spi_ss && spi_sck && !sck_prev)
            sck_rises = sck_rises + 1;
        if (!spi_ss)
            ss_low = ss_low + 1;
        if (spi_ss && !ss_prev)  // ss released, byte over
        begin
            assert (sck_rises == 8)
            else
            begin
                mismatch_errs++;
                $display("mismatch spi_sck_o rising edges got 0x%h expected 0x%h", sck_rises, 8);
            end
            assert (ss_low == 16 * (exp_div + 1))  // 16 half periods of div+1 cycles
            else
            begin
                mismatch_errs++;
                $display("mismatch spi_ss_o low cycles got 0x%h expected 0x%h",
                         ss_low, 16 * (exp_div + 1));
            end
            sck_rises = 0;
            ss_low    = 0;
            xfers     = xfers + 1;
        end
        sck_prev = spi_sck;
        ss_prev  = spi_ss;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    initial
    begin : stimulus
        dev_data_t rd;
        int        lat;
        int        n;
        spi_byte_t b0;
        spi_byte_t b1;
        spi_byte_t b2;
        clk        = 1'b0;
        rst        = 1'b1;
        dev_strobe = 1'b0;
        dev_addr   = '0;
        dev_we     = 1'b0;
        dev_be     = '0;
        dev_din    = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        n = 0;
        while (u_dev_subsys_top.core_rst !== 1'b0 && n < RST_CYCLES + 4)
        begin
            @(posedge clk);
            n++;
        end
        if (n >= RST_CYCLES + 4)
        begin
            other_errs++;
            $display("stretched reset never released");
        end

        // unmapped space answers with zero next cycle
        dev_access(32'h1000_0040, 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (unmapped)", rd, '0);
        compare_word("dev_ready_o latency (unmapped)", 32'(lat), 32'd1);

        // divider register, full and masked writes
        rand_byte(b0);
        dev_access(spi_addr(REG_DIV), 1'b1, 4'hF, {24'h0, b0}, rd, lat);
        dev_access(spi_addr(REG_DIV), 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (DIV)", rd, {24'h0, b0});
        dev_access(spi_addr(REG_DIV), 1'b1, 4'hE, {24'h0, ~b0}, rd, lat);  // byte 0 off
        dev_access(spi_addr(REG_DIV), 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (DIV masked)", rd, {24'h0, b0});

        // first byte, fast divider
        dev_access(spi_addr(REG_DIV), 1'b1, 4'hF, {24'h0, DIV_A}, rd, lat);
        exp_div = DIV_A;
        rand_byte(b1);
        dev_access(spi_addr(REG_TXDATA), 1'b1, 4'hF, {24'h0, b1}, rd, lat);
        dev_access(spi_addr(REG_STATUS), 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (STATUS busy)", {31'h0, rd[0]}, 32'h1);
        compare_word("spi_ss_o", {31'h0, spi_ss}, 32'h0);
        wait_idle();
        dev_access(spi_addr(REG_RXDATA), 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (RXDATA fast)", rd, {24'h0, b1});

        // second byte, slow divider
        dev_access(spi_addr(REG_DIV), 1'b1, 4'hF, {24'h0, DIV_B}, rd, lat);
        exp_div = DIV_B;
        rand_byte(b1);
        dev_access(spi_addr(REG_TXDATA), 1'b1, 4'hF, {24'h0, b1}, rd, lat);
        wait_idle();
        dev_access(spi_addr(REG_RXDATA), 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (RXDATA slow)", rd, {24'h0, b1});

        // txdata while busy must be dropped
        rand_byte(b1);
        rand_byte(b2);
        if (b2 == b1)
            b2 = ~b1;
        dev_access(spi_addr(REG_TXDATA), 1'b1, 4'hF, {24'h0, b1}, rd, lat);
        dev_access(spi_addr(REG_TXDATA), 1'b1, 4'hF, {24'h0, b2}, rd, lat);
        wait_idle();
        dev_access(spi_addr(REG_RXDATA), 1'b0, 4'hF, '0, rd, lat);
        compare_word("dev_dout_o (RXDATA after busy write)", rd, {24'h0, b1});

        repeat (4) @(posedge clk);
        compare_word("spi_ss_o windows", 32'(xfers), 32'd3);  // one per accepted byte

        $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sim.f
hdl/soc_dev_pkg.sv
hdl/axil_if.sv
hdl/reset_stretch.sv
hdl/dev_decoder.sv
hdl/axil_dev_bridge.sv
hdl/spi_regs.sv
hdl/spi_shifter.sv
hdl/dev_subsys_top.sv
verification/tb_dev_subsys.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_dev_subsys
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := *** TEST PASSED ***
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
